//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_cpu -f build.f -o Vtb_cpu

run: compile
	-./obj_dir/Vtb_cpu > sim.log 2>&1
	@cat sim.log
	@if grep -q "Test failures found" sim.log; then exit 1; fi
	@grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

//--- build.f
+incdir+include
logic/cpu_pkg.sv
logic/seq_control.sv
logic/instr_decode.sv
logic/accum_alu.sv
logic/reg_file.sv
logic/bus_interface.sv
logic/cpu_top.sv
verif/cpu_properties.sv
verif/tb_cpu.sv

//--- include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// register codes in the opcode fields
`define REG_CODE_MEM 3'b110
`define REG_CODE_A   3'b111

// opcode field positions
`define OP_SSS_LSB 0
`define OP_DDD_LSB 3
`define OP_FIELD_W 3
`define OP_PFX_LSB 6
`define OP_PFX_W   2

// results of the test programs land here
`define CPU_STORE_ADDR 16'h8000

`endif

//--- logic/accum_alu.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu_consts.svh"

module accum_alu (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_pkg::dp_ctrl_t      ctrl,
  input  logic [`CPU_DATA_W-1:0] int_bus,
  output logic [`CPU_DATA_W-1:0] a_q,
  output logic [`CPU_DATA_W-1:0] tmp_q,
  output logic [`CPU_DATA_W-1:0] alu_q,
  output cpu_pkg::flags_t        flags
);
  import cpu_pkg::*;

  logic [`CPU_DATA_W-1:0] act_q;
  logic [`CPU_DATA_W-1:0] res;
  logic [`CPU_DATA_W:0]   act_x;
  logic [`CPU_DATA_W:0]   tmp_x;
  logic [`CPU_DATA_W:0]   cin_x;
  logic                   cout;
  logic                   a_we;
  flags_t                 flags_next;

  assign act_x = {1'b0, act_q};
  assign tmp_x = {1'b0, tmp_q};
  assign cin_x = {{`CPU_DATA_W{1'b0}}, flags.c};

  always_comb begin
    res  = act_q;
    cout = flags.c;   // INR and DCR keep carry
    case (ctrl.alu_fn)
      ALU_ADD:          {cout, res} = act_x + tmp_x;
      ALU_ADC:          {cout, res} = act_x + tmp_x + cin_x;
      ALU_SUB, ALU_CMP: {cout, res} = act_x - tmp_x;   // top bit is borrow
      ALU_SBB:          {cout, res} = act_x - tmp_x - cin_x;
      ALU_ANA: begin
        res  = act_q & tmp_q;
        cout = 1'b0;
      end
      ALU_XRA: begin
        res  = act_q ^ tmp_q;
        cout = 1'b0;
      end
      ALU_ORA: begin
        res  = act_q | tmp_q;
        cout = 1'b0;
      end
      ALU_INR: res = tmp_q + 1'b1;
      ALU_DCR: res = tmp_q - 1'b1;
      default: res = act_q;
    endcase
  end

  assign flags_next.s = res[`CPU_DATA_W-1];
  assign flags_next.z = (res == '0);
  assign flags_next.p = ~^res;   // even parity
  assign flags_next.c = cout;
  assign alu_q        = res;

  // compare only sets flags
  assign a_we = ctrl.write_a && !(ctrl.a_from_alu && ctrl.alu_fn == ALU_CMP);

  always_ff @(posedge clk) begin
    if (ctrl.write_act) begin
      act_q <= a_q;
    end
    if (ctrl.write_tmp) begin
      tmp_q <= int_bus;
    end
    if (a_we) begin
      a_q <= ctrl.a_from_alu ? alu_q : int_bus;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (ctrl.write_flags) begin
      flags <= flags_next;
    end
  end

endmodule

`default_nettype wire

//--- logic/bus_interface.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu_consts.svh"

module bus_interface (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_pkg::dp_ctrl_t      ctrl,
  input  logic [`CPU_DATA_W-1:0] data_in,
  input  logic [`CPU_DATA_W-1:0] a_q,
  input  logic [`CPU_DATA_W-1:0] tmp_q,
  input  logic [`CPU_DATA_W-1:0] alu_q,
  input  logic [`CPU_DATA_W-1:0] reg_q,
  input  logic [`CPU_ADDR_W-1:0] pc_q,
  input  logic [`CPU_ADDR_W-1:0] wz_q,
  input  logic                   rd_phase,
  input  logic                   wr_phase,
  output logic [`CPU_DATA_W-1:0] int_bus,
  output logic [`CPU_ADDR_W-1:0] addr,
  output logic [`CPU_DATA_W-1:0] data_out,
  output logic                   dbin,
  output logic                   write_n
);
  import cpu_pkg::*;

  always_comb begin
    case (ctrl.bus_src)
      BUS_A:    int_bus = a_q;
      BUS_TMP:  int_bus = tmp_q;
      BUS_ALU:  int_bus = alu_q;
      BUS_REGS: int_bus = reg_q;
      default:  int_bus = data_in;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr <= '0;
    end else if (ctrl.write_addr) begin
      addr <= (ctrl.addr_src == ADDR_WZ) ? wz_q : pc_q;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.write_data_out) begin
      data_out <= int_bus;   // held through the write cycle
    end
  end

  assign dbin    = rd_phase;
  assign write_n = ~wr_phase;

endmodule

`default_nettype wire

//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  typedef enum logic [2:0] {T1, T2, T3, T4, T5, TW, TR} tstate_e;

  typedef enum logic [1:0] {M1, M2, M3, M4} mcycle_e;

  typedef enum logic [3:0] {
    CLS_NOP, CLS_MOV, CLS_MVI, CLS_ALU_REG, CLS_ALU_IMM,
    CLS_INR, CLS_DCR, CLS_JMP, CLS_LDA, CLS_STA
  } instr_class_e;

  // first eight follow opcode bits 5:3
  typedef enum logic [3:0] {
    ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB, ALU_ANA, ALU_XRA, ALU_ORA, ALU_CMP,
    ALU_INR, ALU_DCR
  } alu_fn_e;

  typedef enum logic [2:0] {REG_B, REG_C, REG_D, REG_E, REG_H, REG_L, REG_W, REG_Z} reg_sel_e;

  typedef enum logic [2:0] {BUS_DATA_IN, BUS_A, BUS_TMP, BUS_ALU, BUS_REGS} bus_src_e;

  typedef enum logic {ADDR_PC, ADDR_WZ} addr_src_e;

  typedef struct packed {
    logic s;
    logic z;
    logic p;
    logic c;
  } flags_t;

  typedef struct packed {
    instr_class_e iclass;
    reg_sel_e     sss;
    reg_sel_e     ddd;
    logic         src_is_a;
    logic         dst_is_a;
    alu_fn_e      alu_fn;
    logic         branch_taken;
  } decoded_t;

  typedef struct packed {
    bus_src_e  bus_src;
    reg_sel_e  reg_sel;
    logic      write_regs;
    logic      write_a;
    logic      a_from_alu;
    logic      write_act;
    logic      write_tmp;
    logic      write_flags;
    alu_fn_e   alu_fn;
    logic      inc_pc;
    logic      pc_from_wz;
    logic      write_addr;
    addr_src_e addr_src;
    logic      write_data_out;
    logic      write_instr;
  } dp_ctrl_t;

endpackage

`default_nettype wire

//--- logic/cpu_top.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`CPU_DATA_W-1:0] data_in,
  input  logic                   ready,
  output logic [`CPU_ADDR_W-1:0] addr,
  output logic [`CPU_DATA_W-1:0] data_out,
  output logic                   sync,
  output logic                   dbin,
  output logic                   write_n
);
  import cpu_pkg::*;

  dp_ctrl_t ctrl;
  decoded_t dec;
  flags_t   flags;

  logic [`CPU_DATA_W-1:0] int_bus;
  logic [`CPU_DATA_W-1:0] a_q;
  logic [`CPU_DATA_W-1:0] tmp_q;
  logic [`CPU_DATA_W-1:0] alu_q;
  logic [`CPU_DATA_W-1:0] reg_q;
  logic [`CPU_ADDR_W-1:0] pc_q;
  logic [`CPU_ADDR_W-1:0] wz_q;
  logic                   rd_phase;
  logic                   wr_phase;

  seq_control u_seq (
    .clk      (clk),
    .rst_n    (rst_n),
    .ready    (ready),
    .dec      (dec),
    .ctrl     (ctrl),
    .sync     (sync),
    .rd_phase (rd_phase),
    .wr_phase (wr_phase)
  );

  instr_decode u_dec (
    .clk         (clk),
    .rst_n       (rst_n),
    .write_instr (ctrl.write_instr),
    .int_bus     (int_bus),
    .flags       (flags),
    .dec         (dec)
  );

  accum_alu u_alu (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctrl    (ctrl),
    .int_bus (int_bus),
    .a_q     (a_q),
    .tmp_q   (tmp_q),
    .alu_q   (alu_q),
    .flags   (flags)
  );

  reg_file u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctrl    (ctrl),
    .int_bus (int_bus),
    .reg_q   (reg_q),
    .pc_q    (pc_q),
    .wz_q    (wz_q)
  );

  bus_interface u_bus (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .data_in  (data_in),
    .a_q      (a_q),
    .tmp_q    (tmp_q),
    .alu_q    (alu_q),
    .reg_q    (reg_q),
    .pc_q     (pc_q),
    .wz_q     (wz_q),
    .rd_phase (rd_phase),
    .wr_phase (wr_phase),
    .int_bus  (int_bus),
    .addr     (addr),
    .data_out (data_out),
    .dbin     (dbin),
    .write_n  (write_n)
  );

endmodule

`default_nettype wire

//--- logic/instr_decode.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu_consts.svh"

module instr_decode (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   write_instr,
  input  logic [`CPU_DATA_W-1:0] int_bus,
  input  cpu_pkg::flags_t        flags,
  output cpu_pkg::decoded_t      dec
);
  import cpu_pkg::*;

  logic [`CPU_DATA_W-1:0] instr_q;
  logic [`OP_FIELD_W-1:0] sss_f;
  logic [`OP_FIELD_W-1:0] ddd_f;
  logic [`OP_PFX_W-1:0]   pfx_f;
  logic                   cond;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr_q <= '0;   // NOP
    end else if (write_instr) begin
      instr_q <= int_bus;
    end
  end

  assign sss_f = instr_q[`OP_SSS_LSB +: `OP_FIELD_W];
  assign ddd_f = instr_q[`OP_DDD_LSB +: `OP_FIELD_W];
  assign pfx_f = instr_q[`OP_PFX_LSB +: `OP_PFX_W];

  always_comb begin
    dec.iclass = CLS_NOP;
    casez (instr_q)
      8'b01_???_???: if (ddd_f != `REG_CODE_MEM && sss_f != `REG_CODE_MEM) dec.iclass = CLS_MOV;
      8'b00_???_110: if (ddd_f != `REG_CODE_MEM) dec.iclass = CLS_MVI;
      8'b00_???_100: if (ddd_f != `REG_CODE_MEM) dec.iclass = CLS_INR;
      8'b00_???_101: if (ddd_f != `REG_CODE_MEM) dec.iclass = CLS_DCR;
      8'b00_111_010: dec.iclass = CLS_LDA;
      8'b00_110_010: dec.iclass = CLS_STA;
      8'b10_???_???: if (sss_f != `REG_CODE_MEM) dec.iclass = CLS_ALU_REG;
      8'b11_???_110: dec.iclass = CLS_ALU_IMM;
      8'b11_000_011, 8'b11_???_010: dec.iclass = CLS_JMP;
      default: dec.iclass = CLS_NOP;
    endcase

    if (dec.iclass == CLS_INR) begin
      dec.alu_fn = ALU_INR;
    end else if (dec.iclass == CLS_DCR) begin
      dec.alu_fn = ALU_DCR;
    end else if (pfx_f[1]) begin
      dec.alu_fn = alu_fn_e'({1'b0, ddd_f});   // 10 and 11 prefixes carry the op
    end else begin
      dec.alu_fn = ALU_ADD;
    end
  end

  // NZ Z NC C PO PE P M
  always_comb begin
    case (ddd_f)
      3'd0:    cond = !flags.z;
      3'd1:    cond = flags.z;
      3'd2:    cond = !flags.c;
      3'd3:    cond = flags.c;
      3'd4:    cond = !flags.p;
      3'd5:    cond = flags.p;
      3'd6:    cond = !flags.s;
      default: cond = flags.s;
    endcase
  end

  assign dec.sss          = reg_sel_e'(sss_f);
  assign dec.ddd          = reg_sel_e'(ddd_f);
  assign dec.src_is_a     = (sss_f == `REG_CODE_A);
  assign dec.dst_is_a     = (ddd_f == `REG_CODE_A);
  assign dec.branch_taken = instr_q[0] | cond;   // bit 0 set only for plain JMP

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu_consts.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_pkg::dp_ctrl_t      ctrl,
  input  logic [`CPU_DATA_W-1:0] int_bus,
  output logic [`CPU_DATA_W-1:0] reg_q,
  output logic [`CPU_ADDR_W-1:0] pc_q,
  output logic [`CPU_ADDR_W-1:0] wz_q
);
  import cpu_pkg::*;

  logic [`CPU_DATA_W-1:0] regs [8];   // B C D E H L W Z
  logic [`CPU_ADDR_W-1:0] pc_base;
  logic [`CPU_ADDR_W-1:0] pc_inc;

  always_ff @(posedge clk) begin
    if (ctrl.write_regs) begin
      regs[ctrl.reg_sel] <= int_bus;
    end
  end

  assign reg_q = regs[ctrl.reg_sel];
  assign wz_q  = {regs[REG_W], regs[REG_Z]};

  // taken jump continues from the target
  assign pc_base = ctrl.pc_from_wz ? wz_q : pc_q;
  assign pc_inc  = pc_base + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else if (ctrl.inc_pc) begin
      pc_q <= pc_inc;
    end
  end

endmodule

`default_nettype wire

//--- logic/seq_control.sv
`default_nettype none
`timescale 1ns/100ps

module seq_control (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ready,
  input  cpu_pkg::decoded_t  dec,
  output cpu_pkg::dp_ctrl_t  ctrl,
  output logic               sync,
  output logic               rd_phase,
  output logic               wr_phase
);
  import cpu_pkg::*;

  tstate_e tstate, tstate_next;
  mcycle_e mcycle, mcycle_next;

  logic fetch_wz;   // next opcode comes from WZ
  logic jump_wz;
  logic mcycle_end;
  logic instr_end;
  logic read_sss;
  logic read_ddd;
  logic write_ddd;
  logic data_phase;
  logic stall;
  logic write_cycle;

  assign data_phase  = (tstate == T2) || (tstate == TW);
  assign stall       = data_phase && !ready;
  assign write_cycle = (mcycle == M4) && (dec.iclass == CLS_STA);

  always_comb begin
    ctrl        = '0;
    ctrl.alu_fn = dec.alu_fn;
    read_sss    = 1'b0;
    read_ddd    = 1'b0;
    write_ddd   = 1'b0;
    mcycle_end  = 1'b0;
    instr_end   = 1'b0;
    jump_wz     = 1'b0;

    if (tstate == TR) begin
      instr_end = 1'b1;   // first fetch at PC 0000
    end else begin
      case (mcycle)
        M1: begin
          case (tstate)
            T1: begin
              ctrl.inc_pc     = 1'b1;
              ctrl.pc_from_wz = fetch_wz;
            end
            T2, TW: ctrl.write_instr = 1'b1;
            T3: begin
              if (dec.iclass inside {CLS_MOV, CLS_ALU_REG}) begin
                read_sss       = 1'b1;
                ctrl.write_tmp = 1'b1;
              end
              if (dec.iclass inside {CLS_INR, CLS_DCR}) begin
                read_ddd       = 1'b1;
                ctrl.write_tmp = 1'b1;
              end
              ctrl.write_act = dec.iclass inside {CLS_ALU_REG, CLS_ALU_IMM};
            end
            T4: begin
              case (dec.iclass)
                CLS_MOV: begin
                  ctrl.bus_src = BUS_TMP;
                  write_ddd    = 1'b1;
                end
                CLS_ALU_REG: begin
                  ctrl.write_a     = 1'b1;
                  ctrl.a_from_alu  = 1'b1;
                  ctrl.write_flags = 1'b1;
                  instr_end        = 1'b1;
                end
                CLS_INR, CLS_DCR: begin
                  ctrl.bus_src     = BUS_ALU;
                  ctrl.write_flags = 1'b1;
                  write_ddd        = 1'b1;
                end
                CLS_MVI, CLS_ALU_IMM, CLS_JMP, CLS_LDA, CLS_STA: begin
                  mcycle_end      = 1'b1;   // operand byte follows at PC
                  ctrl.write_addr = 1'b1;
                end
                default: instr_end = 1'b1;
              endcase
            end
            default: begin
              mcycle_end = 1'b1;
              instr_end  = 1'b1;
            end
          endcase
        end

        M2: begin
          case (tstate)
            T1: ctrl.inc_pc = 1'b1;
            T2, TW: begin
              case (dec.iclass)
                CLS_MVI:     write_ddd = 1'b1;
                CLS_ALU_IMM: ctrl.write_tmp = 1'b1;
                default: begin
                  ctrl.reg_sel    = REG_Z;   // low address byte
                  ctrl.write_regs = 1'b1;
                end
              endcase
            end
            default: begin
              mcycle_end = 1'b1;
              if (dec.iclass == CLS_MVI) begin
                instr_end = 1'b1;
              end else if (dec.iclass == CLS_ALU_IMM) begin
                ctrl.write_a     = 1'b1;
                ctrl.a_from_alu  = 1'b1;
                ctrl.write_flags = 1'b1;
                instr_end        = 1'b1;
              end else begin
                ctrl.write_addr = 1'b1;
              end
            end
          endcase
        end

        M3: begin
          case (tstate)
            T1: ctrl.inc_pc = 1'b1;
            T2, TW: begin
              ctrl.reg_sel    = REG_W;
              ctrl.write_regs = 1'b1;
            end
            default: begin
              mcycle_end = 1'b1;
              if (dec.iclass == CLS_JMP) begin
                instr_end = 1'b1;
                jump_wz   = dec.branch_taken;
              end else begin
                ctrl.write_addr = 1'b1;
                ctrl.addr_src   = ADDR_WZ;
              end
            end
          endcase
        end

        default: begin
          case (tstate)
            T1: begin
              if (dec.iclass == CLS_STA) begin
                ctrl.bus_src        = BUS_A;
                ctrl.write_data_out = 1'b1;
              end
            end
            T2, TW: ctrl.write_a = (dec.iclass == CLS_LDA);
            default: instr_end = 1'b1;
          endcase
        end
      endcase
    end

    if (read_sss) begin
      ctrl.reg_sel = dec.sss;
      ctrl.bus_src = dec.src_is_a ? BUS_A : BUS_REGS;
    end
    if (read_ddd) begin
      ctrl.reg_sel = dec.ddd;
      ctrl.bus_src = dec.dst_is_a ? BUS_A : BUS_REGS;
    end
    if (write_ddd) begin
      ctrl.reg_sel    = dec.ddd;
      ctrl.write_a    = dec.dst_is_a;
      ctrl.write_regs = !dec.dst_is_a;
    end

    if (instr_end) begin
      ctrl.write_addr = 1'b1;
      ctrl.addr_src   = jump_wz ? ADDR_WZ : ADDR_PC;
    end
  end

  always_comb begin
    mcycle_next = mcycle;
    case (tstate)
      T1:      tstate_next = T2;
      T2, TW:  tstate_next = T3;
      T3:      tstate_next = T4;
      T4:      tstate_next = T5;
      default: tstate_next = T1;
    endcase
    if (stall) begin
      tstate_next = TW;   // hold until ready
    end else if (instr_end) begin
      mcycle_next = M1;
      tstate_next = T1;
    end else if (mcycle_end) begin
      mcycle_next = mcycle_e'(mcycle + 2'd1);
      tstate_next = T1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tstate   <= TR;
      mcycle   <= M1;
      fetch_wz <= 1'b0;
    end else begin
      tstate   <= tstate_next;
      mcycle   <= mcycle_next;
      fetch_wz <= jump_wz;
    end
  end

  assign sync     = (tstate == T1);
  assign rd_phase = data_phase && !write_cycle;
  assign wr_phase = data_phase && write_cycle;

endmodule

`default_nettype wire

//--- verif/cpu_properties.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpu_properties (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   sync,
  input logic                   dbin,
  input logic                   write_n,
  input logic [`CPU_ADDR_W-1:0] addr
);

  rd_wr_apart: assert property (@(posedge clk) disable iff (!rst_n) !(dbin && !write_n))
    else $error("dbin and write_n active in the same clock");

  // one clock of T1 per machine cycle
  sync_single: assert property (@(posedge clk) disable iff (!rst_n) sync |=> !sync)
    else $error("sync high on two clocks in a row");

  addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (dbin || !write_n) |-> $stable(addr))
    else $error("addr changed during a data phase");

endmodule

bind cpu_top cpu_properties u_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .sync    (sync),
  .dbin    (dbin),
  .write_n (write_n),
  .addr    (addr)
);

`default_nettype wire

//--- verif/tb_cpu.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu_consts.svh"

module tb_cpu;
  localparam logic [1:0] T_ALU  = 2'd0;
  localparam logic [1:0] T_MOVE = 2'd1;
  localparam logic [1:0] T_JCC  = 2'd2;
  localparam logic [1:0] T_LDA  = 2'd3;

  typedef struct packed {
    logic [1:0] tmpl;
    logic [7:0] opc;
  } row_t;

  row_t prog_table [18] = '{
    '{T_ALU, 8'h80}, '{T_ALU, 8'h88}, '{T_ALU, 8'h90}, '{T_ALU, 8'h98},
    '{T_ALU, 8'hA0}, '{T_ALU, 8'hA8}, '{T_ALU, 8'hB0}, '{T_ALU, 8'hB8},
    '{T_MOVE, 8'hC6},
    '{T_JCC, 8'hC2}, '{T_JCC, 8'hCA}, '{T_JCC, 8'hD2}, '{T_JCC, 8'hDA},
    '{T_JCC, 8'hE2}, '{T_JCC, 8'hEA}, '{T_JCC, 8'hF2}, '{T_JCC, 8'hFA},
    '{T_LDA, 8'h3A}
  };

  logic        clk     = 1'b0;
  logic        rst_n   = 1'b0;
  logic        ready   = 1'b1;
  logic [7:0]  data_in = 8'h00;
  logic [15:0] addr;
  logic [7:0]  data_out;
  logic        sync;
  logic        dbin;
  logic        write_n;

  logic [7:0]  mem [65536];
  int          wait_tbl [64];   // wait clocks per machine cycle
  int          wt_idx, left, wait_tot, last_n, cnt, wr_cyc, wr_waits;
  logic        started, wr_seen, first_wn;
  logic        wn_prev = 1'b1;
  logic [15:0] first_addr, wr_addr;
  logic [7:0]  wr_data;
  logic [15:0] ld_ptr;
  int          exp_t;
  int          exp_rd;
  int          rd_clks;

  always #10 clk = ~clk;

  cpu_top uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .data_in  (data_in),
    .ready    (ready),
    .addr     (addr),
    .data_out (data_out),
    .sync     (sync),
    .dbin     (dbin),
    .write_n  (write_n)
  );

  // memory model, wait-state source and write recorder
  always @(posedge clk) begin
    data_in <= mem[addr];   // addr is stable from T1 on
    wn_prev <= write_n;
    if (!rst_n) begin
      ready    <= 1'b1;
      started  <= 1'b0;
      wr_seen  <= 1'b0;
      cnt      <= 0;
      wt_idx   <= 0;
      left     <= 0;
      wait_tot <= 0;
      last_n   <= 0;
      rd_clks  <= 0;
    end else begin
      if (started) cnt <= cnt + 1;
      if (started && dbin && !wr_seen) rd_clks <= rd_clks + 1;
      if (sync) begin
        if (!started) begin
          started    <= 1'b1;
          first_addr <= addr;
          first_wn   <= write_n;
        end
        ready    <= (wait_tbl[wt_idx] == 0);
        left     <= wait_tbl[wt_idx];
        wait_tot <= wait_tot + wait_tbl[wt_idx];
        last_n   <= wait_tbl[wt_idx];
        wt_idx   <= (wt_idx + 1) % 64;
      end else if (left > 0) begin
        left  <= left - 1;
        ready <= (left == 1);
      end
      if (!write_n && wn_prev && !wr_seen) begin
        wr_seen  <= 1'b1;
        wr_addr  <= addr;
        wr_data  <= data_out;
        wr_cyc   <= cnt + 1;
        wr_waits <= wait_tot - last_n;   // waits of the write cycle come later
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // machine cycles that read, from the T-state total
  function automatic int read_cycles(input int t);
    case (t)
      4, 5:    return 1;
      7:       return 2;
      10, 11:  return 3;   // a store reads three before its write
      13:      return 4;
      default: return 0;
    endcase
  endfunction

  task automatic emit1(input logic [7:0] op, input int t);
    mem[ld_ptr] = op;
    ld_ptr = ld_ptr + 16'd1;
    exp_t = exp_t + t;
    exp_rd = exp_rd + read_cycles(t);
  endtask

  task automatic emit2(input logic [7:0] op, input logic [7:0] imm, input int t);
    emit1(op, t);
    emit1(imm, 0);
  endtask

  task automatic emit3(input logic [7:0] op, input logic [15:0] a16, input int t);
    emit1(op, t);
    emit1(a16[7:0], 0);
    emit1(a16[15:8], 0);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic wait_write();
    int n;
    n = 0;
    while (!wr_seen && n < 400) begin
      @(posedge clk);
      n++;
    end
    if (!wr_seen) begin
      $display("no store to the result address within 400 clocks");
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  function automatic logic [7:0] alu_model(input logic [2:0] fn, input logic [7:0] x,
                                           input logic [7:0] y, input logic cin);
    case (fn)
      3'd0:    return x + y;
      3'd1:    return x + y + 8'(cin);
      3'd2:    return x - y;
      3'd3:    return x - y - 8'(cin);
      3'd4:    return x & y;
      3'd5:    return x ^ y;
      3'd6:    return x | y;
      default: return x;   // compare leaves A alone
    endcase
  endfunction

  function automatic logic cond_met(input logic [2:0] cc, input logic [7:0] x,
                                    input logic [7:0] y, input logic is_sub);
    logic [7:0] r;
    logic       c;
    r = is_sub ? x - y : x + y;
    c = is_sub ? (x < y) : ((32'(x) + 32'(y)) > 32'd255);
    case (cc)
      3'd0:    return r != 8'h00;
      3'd1:    return r == 8'h00;
      3'd2:    return !c;
      3'd3:    return c;
      3'd4:    return ^r;   // parity odd
      3'd5:    return ~^r;
      3'd6:    return !r[7];
      default: return r[7];
    endcase
  endfunction

  initial begin
    row_t        row;
    logic [7:0]  x, y, k, b, exp_v;
    logic        use_cpi, cin;
    logic [15:0] exp_a;
    void'($urandom(45097));
    for (int i = 0; i < 65536; i++) begin
      mem[16'(i)] = 8'(i) ^ 8'(i >> 8) ^ 8'hA5;
    end
    for (int pass = 0; pass < 2; pass++) begin
      for (int r = 0; r < 18; r++) begin
        for (int it = 0; it < 3; it++) begin
          row = prog_table[r];
          for (int n = 0; n < 64; n++) begin
            wait_tbl[n] = (pass == 1) ? int'($urandom % 4) : 0;
          end
          x       = 8'($urandom);
          y       = 8'($urandom);
          k       = 8'($urandom);
          b       = 8'($urandom);
          use_cpi = 1'($urandom);
          ld_ptr  = 16'h0000;
          exp_t   = 0;
          exp_rd  = 0;
          exp_a   = `CPU_STORE_ADDR;
          case (row.tmpl)
            T_ALU: begin
              emit2(8'h3E, x, 7);
              if (use_cpi) emit2(8'hFE, 8'hFF, 7);   // carry set unless x is FF
              else emit1(8'hB7, 4);
              cin = use_cpi && (x != 8'hFF);
              emit2(8'h06, y, 7);
              emit1(row.opc, 4);
              emit3(8'h32, exp_a, 11);
              exp_v = alu_model(row.opc[5:3], x, y, cin);
            end
            T_MOVE: begin
              emit2(8'h0E, x, 7);
              emit1(8'h0C, 5);
              emit1(8'h51, 5);
              emit1(8'h15, 5);
              emit1(8'h15, 5);
              emit1(8'h7A, 5);
              emit2(8'hC6, y, 7);
              emit3(8'h32, exp_a, 11);
              exp_v = x - 8'd1 + y;
            end
            T_JCC: begin
              if (it == 0) y = x;
              if (it == 1) y = 8'h00 - x;
              emit2(8'h3E, x, 7);
              emit2(use_cpi ? 8'hFE : 8'hC6, y, 7);
              emit3(row.opc, 16'h0010, 10);
              emit2(8'h3E, 8'h02, 7);
              emit3(8'h32, exp_a, 11);
              ld_ptr = 16'h0010;   // taken path of the same length
              emit2(8'h3E, 8'h01, 0);
              emit3(8'h32, exp_a, 0);
              exp_v = cond_met(row.opc[5:3], x, y, use_cpi) ? 8'h01 : 8'h02;
            end
            default: begin
              mem[16'h9000] = b;
              exp_a = `CPU_STORE_ADDR + 16'd1;
              emit3(8'h3A, 16'h9000, 13);
              emit2(8'hEE, k, 7);
              emit3(8'h32, exp_a, 11);
              exp_v = b ^ k;
            end
          endcase
          apply_reset();
          wait_write();
          check_value("first_sync_addr", 32'(first_addr), 32'h0);
          check_value("first_sync_write_n", 32'(first_wn), 32'h1);
          check_value("write_addr", 32'(wr_addr), 32'(exp_a));
          check_value("write_data", 32'(wr_data), 32'(exp_v));
          check_value("clocks_to_write", 32'(wr_cyc), 32'(exp_t + wr_waits));
          check_value("dbin_clocks", 32'(rd_clks), 32'(exp_rd + wr_waits));
        end
      end
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire
